// ==== src/alu_op_pkg.sv ====
package alu_op_pkg;

    localparam int ALU_SEL_BITS   = 7;
    localparam int DATA_BITS      = 32;
    localparam int W_BITS         = 3;
    localparam int SHIFT_CNT_BITS = 4;   // low bits of op2, 0 means 16

    // one-hot width, zero means no operation
    localparam logic [W_BITS-1:0] W_BYTE = 3'b001;
    localparam logic [W_BITS-1:0] W_WORD = 3'b010;
    localparam logic [W_BITS-1:0] W_LONG = 3'b100;

    localparam logic [ALU_SEL_BITS-1:0] ALU_MOVE = 7'd0;
    localparam logic [ALU_SEL_BITS-1:0] ALU_ADD  = 7'd1;   // add family
    localparam logic [ALU_SEL_BITS-1:0] ALU_ADC  = 7'd2;
    localparam logic [ALU_SEL_BITS-1:0] ALU_INC  = 7'd3;
    localparam logic [ALU_SEL_BITS-1:0] ALU_SUB  = 7'd4;   // subtract family
    localparam logic [ALU_SEL_BITS-1:0] ALU_SBC  = 7'd5;
    localparam logic [ALU_SEL_BITS-1:0] ALU_CP   = 7'd6;
    localparam logic [ALU_SEL_BITS-1:0] ALU_DEC  = 7'd7;
    localparam logic [ALU_SEL_BITS-1:0] ALU_NEG  = 7'd8;
    localparam logic [ALU_SEL_BITS-1:0] ALU_AND  = 7'd9;   // logic
    localparam logic [ALU_SEL_BITS-1:0] ALU_OR   = 7'd10;
    localparam logic [ALU_SEL_BITS-1:0] ALU_XOR  = 7'd11;
    localparam logic [ALU_SEL_BITS-1:0] ALU_CPL  = 7'd12;
    localparam logic [ALU_SEL_BITS-1:0] ALU_BIT  = 7'd13;  // register bit ops
    localparam logic [ALU_SEL_BITS-1:0] ALU_SET  = 7'd14;
    localparam logic [ALU_SEL_BITS-1:0] ALU_RES  = 7'd15;
    localparam logic [ALU_SEL_BITS-1:0] ALU_CHG  = 7'd16;
    localparam logic [ALU_SEL_BITS-1:0] ALU_TSET = 7'd17;
    localparam logic [ALU_SEL_BITS-1:0] ALU_ZCF  = 7'd18;  // carry flag ops
    localparam logic [ALU_SEL_BITS-1:0] ALU_CCF  = 7'd19;
    localparam logic [ALU_SEL_BITS-1:0] ALU_SCF  = 7'd20;
    localparam logic [ALU_SEL_BITS-1:0] ALU_RCF  = 7'd21;
    localparam logic [ALU_SEL_BITS-1:0] ALU_RLC  = 7'd22;  // multi-cycle shifts
    localparam logic [ALU_SEL_BITS-1:0] ALU_RRC  = 7'd23;
    localparam logic [ALU_SEL_BITS-1:0] ALU_RL   = 7'd24;
    localparam logic [ALU_SEL_BITS-1:0] ALU_RR   = 7'd25;
    localparam logic [ALU_SEL_BITS-1:0] ALU_SLA  = 7'd26;
    localparam logic [ALU_SEL_BITS-1:0] ALU_SRA  = 7'd27;
    localparam logic [ALU_SEL_BITS-1:0] ALU_SLL  = 7'd28;
    localparam logic [ALU_SEL_BITS-1:0] ALU_SRL  = 7'd29;

endpackage

// ==== src/alu_flag_pkg.sv ====
package alu_flag_pkg;

    localparam int FLAG_BITS = 8;

    // flag byte layout, bits 5 and 3 read as 0
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    // w[0] selects byte, w[1] word, anything else long
    function automatic logic width_sign(input logic [31:0] x, input logic [2:0] w);
        return w[0] ? x[7] : w[1] ? x[15] : x[31];
    endfunction

    function automatic logic width_zero(input logic [31:0] x, input logic [2:0] w);
        if (w[0]) begin
            return x[7:0] == '0;
        end
        if (w[1]) begin
            return x[15:0] == '0;
        end
        return x == '0;
    endfunction

    // parity never looks past bit 15
    function automatic logic width_even(input logic [31:0] x, input logic [2:0] w);
        return w[0] ? ~^x[7:0] : ~^x[15:0];
    endfunction

endpackage

// ==== src/alu_addsub.sv ====
`timescale 1ns/100ps

module alu_addsub import alu_op_pkg::*, alu_flag_pkg::*; (
    input  logic [ALU_SEL_BITS-1:0] sel,
    input  logic [W_BITS-1:0]       w,
    input  logic [DATA_BITS-1:0]    op0,
    input  logic [DATA_BITS-1:0]    op2,
    input  logic [FLAG_BITS-1:0]    flags,
    output logic                    hit,
    output logic [DATA_BITS-1:0]    result,
    output logic [FLAG_BITS-1:0]    next_flags
);

    logic                 is_add, is_sub, is_neg, keep_c, keep_all;
    logic                 cin, ci, c_h, c_b, c_w, c_l, ovf;
    logic [DATA_BITS-1:0] a, b, bx;
    logic [DATA_BITS:0]   ext_a, ext_b, ext_r;

    function automatic logic [DATA_BITS:0] extend(input logic [DATA_BITS-1:0] x,
                                                  input logic [W_BITS-1:0] wc);
        case (wc)
            W_BYTE:  return {{25{x[7]}}, x[7:0]};
            W_WORD:  return {{17{x[15]}}, x[15:0]};
            default: return {x[31], x};
        endcase
    endfunction

    assign is_add   = sel inside {ALU_ADD, ALU_ADC, ALU_INC};
    assign is_sub   = sel inside {ALU_SUB, ALU_SBC, ALU_CP, ALU_DEC, ALU_NEG};
    assign is_neg   = sel == ALU_NEG;
    assign hit      = is_add | is_sub;
    assign keep_c   = sel inside {ALU_INC, ALU_DEC};
    assign keep_all = keep_c && (w == W_WORD || w == W_LONG);

    assign a   = is_neg ? '0 : op0;   // NEG is 0 - op0
    assign b   = is_neg ? op0 : op2;
    assign cin = (sel == ALU_ADC || sel == ALU_SBC) && flags[FLAG_C];

    // subtraction as a + ~b + ~borrow, carries flip back to borrows
    assign bx = is_sub ? ~b : b;
    assign ci = is_sub ? ~cin : cin;

    assign {c_h, result[3:0]}   = {1'b0, a[3:0]}   + {1'b0, bx[3:0]}   + {4'd0, ci};
    assign {c_b, result[7:4]}   = {1'b0, a[7:4]}   + {1'b0, bx[7:4]}   + {4'd0, c_h};
    assign {c_w, result[15:8]}  = {1'b0, a[15:8]}  + {1'b0, bx[15:8]}  + {8'd0, c_b};
    assign {c_l, result[31:16]} = {1'b0, a[31:16]} + {1'b0, bx[31:16]} + {16'd0, c_w};

    // overflow from a sign-extended copy
    assign ext_a = extend(a, w);
    assign ext_b = extend(b, w);
    assign ext_r = is_sub ? ext_a - ext_b - {32'd0, cin} : ext_a + ext_b + {32'd0, cin};
    assign ovf   = ext_r[DATA_BITS] ^ width_sign(result, w);

    always_comb begin
        next_flags = flags;
        if (!keep_all) begin
            next_flags[FLAG_S] = width_sign(result, w);
            next_flags[FLAG_Z] = width_zero(result, w);
            next_flags[FLAG_H] = c_h ^ is_sub;
            next_flags[FLAG_V] = ovf;
            next_flags[FLAG_N] = is_sub;
            if (!keep_c) begin
                next_flags[FLAG_C] = (w[0] ? c_b : w[1] ? c_w : c_l) ^ is_sub;
            end
        end
    end

endmodule

// ==== src/alu_logic_bit.sv ====
`timescale 1ns/100ps

module alu_logic_bit import alu_op_pkg::*, alu_flag_pkg::*; (
    input  logic [ALU_SEL_BITS-1:0] sel,
    input  logic [W_BITS-1:0]       w,
    input  logic [DATA_BITS-1:0]    op0,
    input  logic [DATA_BITS-1:0]    op2,
    input  logic [FLAG_BITS-1:0]    flags,
    output logic                    hit,
    output logic [DATA_BITS-1:0]    result,
    output logic [FLAG_BITS-1:0]    next_flags
);

    logic [SHIFT_CNT_BITS-1:0] bit_idx;

    assign bit_idx = op2[SHIFT_CNT_BITS-1:0];   // bit 0..15 of op0

    always_comb begin
        hit        = 1'b1;
        result     = op0;
        next_flags = flags;
        case (sel)
            ALU_AND, ALU_OR, ALU_XOR: begin
                result = sel == ALU_AND ? op0 & op2 :
                         sel == ALU_OR  ? op0 | op2 : op0 ^ op2;
                next_flags[FLAG_S] = width_sign(result, w);
                next_flags[FLAG_Z] = width_zero(result, w);
                next_flags[FLAG_H] = sel == ALU_AND;
                next_flags[FLAG_V] = width_even(result, w);
                next_flags[FLAG_N] = 1'b0;
                next_flags[FLAG_C] = 1'b0;
            end
            ALU_CPL: begin
                result = ~op2;
                next_flags[FLAG_H] = 1'b1;
                next_flags[FLAG_N] = 1'b1;
            end
            ALU_BIT, ALU_TSET: begin
                result[bit_idx] = sel == ALU_TSET ? 1'b1 : op0[bit_idx];
                next_flags[FLAG_Z] = ~op0[bit_idx];   // tested before set
                next_flags[FLAG_H] = 1'b1;
                next_flags[FLAG_N] = 1'b0;
            end
            ALU_SET: result[bit_idx] = 1'b1;
            ALU_RES: result[bit_idx] = 1'b0;
            ALU_CHG: result[bit_idx] = ~op0[bit_idx];
            default: hit = 1'b0;
        endcase
    end

endmodule

// ==== src/alu_shifter.sv ====
`timescale 1ns/100ps

module alu_shifter import alu_op_pkg::*, alu_flag_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [ALU_SEL_BITS-1:0] sel,
    input  logic [W_BITS-1:0]       w,
    input  logic [DATA_BITS-1:0]    op0,
    input  logic [DATA_BITS-1:0]    op2,
    input  logic [FLAG_BITS-1:0]    flags,
    output logic                    hit,
    output logic                    busy,
    output logic                    done,
    output logic [DATA_BITS-1:0]    result,
    output logic [FLAG_BITS-1:0]    next_flags
);

    logic [DATA_BITS-1:0]      work, src, left, right;
    logic [SHIFT_CNT_BITS-1:0] cnt;
    logic                      cy, ci, msb, lin, rin, go_left, co;

    assign hit     = sel inside {ALU_RLC, ALU_RRC, ALU_RL, ALU_RR,
                                 ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL};
    assign go_left = sel inside {ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL};

    // first step works on op0, later ones on the working copy
    assign src = busy ? work : op0;
    assign ci  = busy ? cy : flags[FLAG_C];
    assign msb = width_sign(src, w);
    assign lin = sel == ALU_RL ? ci : sel == ALU_RLC ? msb : 1'b0;
    assign rin = sel == ALU_RR  ? ci :
                 sel == ALU_RRC ? src[0] :
                 sel == ALU_SRA ? msb : 1'b0;   // SRA keeps the sign
    assign co  = go_left ? msb : src[0];

    assign done = hit && (busy ? cnt == 1 : op2[SHIFT_CNT_BITS-1:0] == 1);

    always_comb begin
        left  = src;
        right = src;
        case (w)
            W_BYTE: begin
                left[7:0]  = {src[6:0], lin};
                right[7:0] = {rin, src[7:1]};
            end
            W_WORD: begin
                left[15:0]  = {src[14:0], lin};
                right[15:0] = {rin, src[15:1]};
            end
            default: begin
                left  = {src[30:0], lin};
                right = {rin, src[31:1]};
            end
        endcase
        result = go_left ? left : right;
        next_flags = flags;
        next_flags[FLAG_S] = width_sign(result, w);
        next_flags[FLAG_Z] = width_zero(result, w);
        next_flags[FLAG_H] = 1'b0;
        next_flags[FLAG_V] = width_even(result, w);
        next_flags[FLAG_N] = 1'b0;
        next_flags[FLAG_C] = co;   // last bit out
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (cen && hit && w != '0) begin
            busy <= !done;
            cnt  <= (busy ? cnt : op2[SHIFT_CNT_BITS-1:0]) - 1'b1;   // 0 wraps to 15
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            work <= result;
            cy   <= co;
        end
    end

endmodule

// ==== src/alu_writeback.sv ====
`timescale 1ns/100ps

module alu_writeback import alu_op_pkg::*, alu_flag_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [W_BITS-1:0]       w,
    input  logic                    flag_we,
    input  logic [ALU_SEL_BITS-1:0] sel,
    input  logic [DATA_BITS-1:0]    op2,
    input  logic                    add_hit,
    input  logic [DATA_BITS-1:0]    add_result,
    input  logic [FLAG_BITS-1:0]    add_flags,
    input  logic                    logic_hit,
    input  logic [DATA_BITS-1:0]    logic_result,
    input  logic [FLAG_BITS-1:0]    logic_flags,
    input  logic                    shift_hit,
    input  logic [DATA_BITS-1:0]    shift_result,
    input  logic [FLAG_BITS-1:0]    shift_flags,
    input  logic                    shift_done,
    input  logic                    shift_busy,
    output logic [DATA_BITS-1:0]    dout,
    output logic [FLAG_BITS-1:0]    flags,
    output logic [W_BITS-1:0]       alu_we,
    output logic                    flag_only
);

    logic [DATA_BITS-1:0] nx_result;
    logic [FLAG_BITS-1:0] nx_flags;
    logic                 flag_wel, fwe_rise, stall;

    assign stall    = (shift_hit | shift_busy) & ~shift_done;   // shift still running
    assign fwe_rise = flag_we & ~flag_wel;

    always_comb begin
        nx_result = dout;
        nx_flags  = flags;
        if (add_hit) begin
            nx_result = add_result;
            nx_flags  = add_flags;
        end else if (logic_hit) begin
            nx_result = logic_result;
            nx_flags  = logic_flags;
        end else if (shift_hit) begin
            nx_result = shift_result;
            nx_flags  = shift_flags;
        end else begin
            case (sel)
                ALU_MOVE: nx_result = op2;
                ALU_ZCF: nx_flags[FLAG_C] = ~flags[FLAG_Z];
                ALU_CCF: nx_flags[FLAG_C] = ~flags[FLAG_C];
                ALU_SCF: nx_flags[FLAG_C] = 1'b1;
                ALU_RCF: nx_flags[FLAG_C] = 1'b0;
                default: ;
            endcase
            if (sel inside {ALU_ZCF, ALU_CCF, ALU_SCF, ALU_RCF}) begin
                nx_flags[FLAG_N] = 1'b0;
            end
            if (sel inside {ALU_SCF, ALU_RCF}) begin
                nx_flags[FLAG_H] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout      <= '0;
            flags     <= '0;
            alu_we    <= '0;
            flag_only <= 1'b0;
            flag_wel  <= 1'b0;
        end else if (cen) begin
            flag_wel  <= flag_we;
            flag_only <= flag_we;
            alu_we    <= stall ? '0 : w;
            if (w != '0 && !stall && sel != ALU_CP) begin   // compare leaves dout alone
                dout <= nx_result;
            end
            if ((w != '0 || fwe_rise) && !stall) begin
                flags <= nx_flags;
            end
        end
    end

endmodule

// ==== src/alu_top.sv ====
`timescale 1ns/100ps

module alu_top import alu_op_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [ALU_SEL_BITS-1:0] sel,
    input  logic [W_BITS-1:0]       w,
    input  logic [DATA_BITS-1:0]    op0,
    input  logic [DATA_BITS-1:0]    op1,
    input  logic [DATA_BITS-1:0]    imm,
    input  logic                    sel_imm,
    input  logic                    flag_we,
    output logic [DATA_BITS-1:0]    dout,
    output logic [7:0]              flags,
    output logic [W_BITS-1:0]       alu_we,
    output logic                    flag_only,
    output logic                    busy
);

    logic [DATA_BITS-1:0] op2, add_result, logic_result, shift_result;
    logic [7:0]           add_flags, logic_flags, shift_flags;
    logic                 add_hit, logic_hit, shift_hit, shift_done;

    assign op2 = sel_imm ? imm : op1;   // second operand for every unit

    alu_addsub addsub_inst (
        .sel(sel), .w(w), .op0(op0), .op2(op2), .flags(flags),
        .hit(add_hit), .result(add_result), .next_flags(add_flags)
    );

    alu_logic_bit logic_bit_inst (
        .sel(sel), .w(w), .op0(op0), .op2(op2), .flags(flags),
        .hit(logic_hit), .result(logic_result), .next_flags(logic_flags)
    );

    alu_shifter shifter_inst (
        .clk(clk), .rst(rst), .cen(cen), .sel(sel), .w(w), .op0(op0), .op2(op2),
        .flags(flags), .hit(shift_hit), .busy(busy), .done(shift_done),
        .result(shift_result), .next_flags(shift_flags)
    );

    alu_writeback writeback_inst (
        .clk(clk), .rst(rst), .cen(cen), .w(w), .flag_we(flag_we), .sel(sel), .op2(op2),
        .add_hit(add_hit), .add_result(add_result), .add_flags(add_flags),
        .logic_hit(logic_hit), .logic_result(logic_result), .logic_flags(logic_flags),
        .shift_hit(shift_hit), .shift_result(shift_result), .shift_flags(shift_flags),
        .shift_done(shift_done), .shift_busy(busy),
        .dout(dout), .flags(flags), .alu_we(alu_we), .flag_only(flag_only)
    );

endmodule

// ==== dv/alu_tb.sv ====
`timescale 1ns/100ps

module alu_tb import alu_op_pkg::*, alu_flag_pkg::*; ();

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cen;
    logic [ALU_SEL_BITS-1:0] sel;
    logic [W_BITS-1:0]       w;
    logic [DATA_BITS-1:0]    op0, op1, imm;
    logic                    sel_imm, flag_we;
    logic [DATA_BITS-1:0]    dout;
    logic [FLAG_BITS-1:0]    flags;
    logic [W_BITS-1:0]       alu_we;
    logic                    flag_only, busy;

    logic [31:0] lfsr = 32'h188d_c3fa;

    // one entry per golden line
    logic [ALU_SEL_BITS-1:0] v_sel[$];
    logic [W_BITS-1:0]       v_w[$];
    logic [DATA_BITS-1:0]    v_op0[$], v_op1[$], v_imm[$], v_dout[$];
    logic                    v_sel_imm[$], v_flag_we[$];
    logic [FLAG_BITS-1:0]    v_flags[$];

    alu_top alu_top_inst (
        .clk(clk), .rst(rst), .cen(cen), .sel(sel), .w(w), .op0(op0), .op1(op1),
        .imm(imm), .sel_imm(sel_imm), .flag_we(flag_we), .dout(dout), .flags(flags),
        .alu_we(alu_we), .flag_only(flag_only), .busy(busy)
    );

    always #10 clk = ~clk;   // 20 ns period

    // galois form, one step per bit
    function automatic logic random_bit();
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        return lfsr[0];
    endfunction

    function automatic logic pick_cen();
        logic a, b;
        a = random_bit();
        b = random_bit();
        return !(a && b);   // drop about one cycle in four
    endfunction

    task automatic check_data(input string name, input logic [DATA_BITS-1:0] got,
                              input logic [DATA_BITS-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_flags(input string name, input logic [FLAG_BITS-1:0] got,
                               input logic [FLAG_BITS-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_width(input string name, input logic [W_BITS-1:0] got,
                               input logic [W_BITS-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic load_vectors();
        int    fd, code, n;
        string line;
        logic [ALU_SEL_BITS-1:0] t_sel;
        logic [W_BITS-1:0]       t_w;
        logic [DATA_BITS-1:0]    t_op0, t_op1, t_imm, t_dout;
        logic                    t_sel_imm, t_flag_we;
        logic [FLAG_BITS-1:0]    t_flags;
        fd = $fopen("dv/alu_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden vector file");
            $display("ERRORS FOUND");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", t_sel, t_w, t_op0,
                            t_op1, t_imm, t_sel_imm, t_flag_we, t_dout, t_flags);
                if (n == 9) begin
                    v_sel.push_back(t_sel);
                    v_w.push_back(t_w);
                    v_op0.push_back(t_op0);
                    v_op1.push_back(t_op1);
                    v_imm.push_back(t_imm);
                    v_sel_imm.push_back(t_sel_imm);
                    v_flag_we.push_back(t_flag_we);
                    v_dout.push_back(t_dout);
                    v_flags.push_back(t_flags);
                end
            end
        end
        $fclose(fd);
    endtask

    // called on a falling edge, returns on the falling edge after completion
    task automatic run_vector(input int i);
        logic                 en, finished;
        int                   edges, steps;
        logic [DATA_BITS-1:0] op2_val;
        op2_val = v_sel_imm[i] ? v_imm[i] : v_op1[i];
        steps   = 1;
        if (v_sel[i] inside {ALU_RLC, ALU_RRC, ALU_RL, ALU_RR,
                             ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL}) begin
            steps = int'(op2_val[SHIFT_CNT_BITS-1:0]);   // one bit per enabled edge
            if (steps == 0) begin
                steps = 16;
            end
        end
        edges    = 0;
        sel      = v_sel[i];
        w        = v_w[i];
        op0      = v_op0[i];
        op1      = v_op1[i];
        imm      = v_imm[i];
        sel_imm  = v_sel_imm[i];
        flag_we  = v_flag_we[i];
        cen      = pick_cen();
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk);
            en = cen;
            @(negedge clk);
            if (en) begin
                edges = edges + 1;
                if (alu_we != '0 || flag_only) begin
                    finished = 1'b1;
                end else begin
                    check_bit("busy", busy, 1'b1);   // shift still in progress
                end
            end
            if (!finished) begin
                cen = pick_cen();
            end
        end
        check_count("enabled edges", edges, steps);
        check_data("dout", dout, v_dout[i]);
        check_flags("flags", flags, v_flags[i]);
        check_width("alu_we", alu_we, v_w[i]);
        check_bit("busy", busy, 1'b0);
        check_bit("flag_only", flag_only, v_flag_we[i]);
    endtask

    initial begin
        longint limit;
        rst     = 1'b1;
        cen     = 1'b1;
        sel     = '0;
        w       = '0;
        op0     = '0;
        op1     = '0;
        imm     = '0;
        sel_imm = 1'b0;
        flag_we = 1'b0;
        load_vectors();
        limit = longint'(v_sel.size() + 4) * 40 * 20;
        fork
            begin
                #(limit);
                $display("simulation timed out waiting for the ALU");
                $display("ERRORS FOUND");
                $fatal(1);
            end
        join_none
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_data("dout", dout, '0);
        check_flags("flags", flags, '0);
        check_width("alu_we", alu_we, '0);
        check_bit("busy", busy, 1'b0);
        check_bit("flag_only", flag_only, 1'b0);
        for (int i = 0; i < v_sel.size(); i++) begin
            run_vector(i);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== dv/alu_golden.txt ====
# sel w op0 op1 imm sel_imm flag_we exp_dout exp_flags, all hex
# flags are S Z - H - V N C, shift count in op1 low 4 bits (0 means 16)
00 4 00000000 00000000 12345678 1 0 12345678 00
01 1 0000007f 00000001 00000000 0 0 00000080 94
02 1 000000ff 00000001 00000000 0 0 00000100 51
02 2 00001234 ffffffff 00000001 1 0 00001236 00
04 4 00000000 00000001 00000000 0 0 ffffffff 93
05 1 00000010 00000001 00000000 0 0 0000000e 12
06 1 00000005 00000005 00000000 0 0 0000000e 42
08 2 00000001 00000000 00000000 0 0 ffffffff 93
03 2 0000ffff 00000001 00000000 0 0 00010000 93
07 2 00000000 00000001 00000000 0 0 ffffffff 93
03 1 0000007f 00000001 00000000 0 0 00000080 95
09 1 000000f0 0000003c 00000000 0 0 00000030 14
0a 2 00008000 00000001 00000000 0 0 00008001 84
0b 1 000000ff 000000fe 00000000 0 0 00000001 00
0c 4 00000000 00000000 0f0f0f0f 1 0 f0f0f0f0 12
0d 2 00000100 00000008 00000000 0 0 00000100 10
0d 2 00000100 00000003 00000000 0 0 00000100 50
0e 2 00000000 0000000f 00000000 0 0 00008000 50
0f 4 ffffffff 00000000 00000000 0 0 fffffffe 50
10 1 00000010 00000004 00000000 0 0 00000000 50
11 1 00000004 00000002 00000000 0 0 00000004 10
12 0 00000000 00000000 00000000 0 1 00000004 11
13 0 00000000 00000000 00000000 0 1 00000004 11
16 1 00000081 00000001 00000000 0 0 00000003 05
17 1 00000001 00000005 00000000 0 0 00000008 00
18 2 00008000 00000000 00000000 0 0 00004000 00
19 4 00000001 00000001 00000000 0 0 00000000 45
1a 1 00000007 00000005 00000000 0 0 000000e0 80
1b 2 00008000 00000000 00000000 0 0 0000ffff 85
1c 4 80000001 00000001 00000000 0 0 00000002 01
1d 1 000000ff 00000000 00000000 0 0 00000000 44
14 0 00000000 00000000 00000000 0 1 00000000 45
13 0 00000000 00000000 00000000 0 1 00000000 45
00 1 00000000 000000aa 00000000 0 0 000000aa 45
15 0 00000000 00000000 00000000 0 1 000000aa 44
00 2 00000000 00005555 00000000 0 0 00005555 44
13 0 00000000 00000000 00000000 0 1 00005555 45

// ==== compile.f ====
src/alu_op_pkg.sv
src/alu_flag_pkg.sv
src/alu_addsub.sv
src/alu_logic_bit.sv
src/alu_shifter.sv
src/alu_writeback.sv
src/alu_top.sv
dv/alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ALU testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module alu_tb -o alu_sim || exit 1

./obj_dir/alu_sim > sim.log 2>&1

grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
